/* include/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// ==========================================================
// Cache geometry
// ==========================================================

// Byte address width seen by both sides
`define CACHE_ADDR_W 32
// One line is four 32-bit words
`define CACHE_LINE_BYTES 16
`define CACHE_SETS 16
`define CACHE_OFFSET_W 4
`define CACHE_SET_W 4
// Whatever is left above set and offset
`define CACHE_TAG_W 24
`define CACHE_WORDS_PER_LINE 4
`define CACHE_WORD_IDX_W 2

// ==========================================================
// Memory bus
// ==========================================================
`define BUS_DATA_W 64
// Two requester words per beat, so a line is a two-beat burst
`define BUS_WORDS_PER_BEAT 2
`define BUS_LANE_W 1

`endif

/* source/cache_geom_pkg.sv */
`include "cache_defs.svh"

package cache_geom_pkg;

  // ==========================================================
  // Address fields
  // ==========================================================

  // Upper address bits kept per set
  typedef logic [`CACHE_TAG_W-1:0] tag_t;

  // Set index, picks the single line of a direct-mapped set
  typedef logic [`CACHE_SET_W-1:0] set_t;

  // Word position inside one line
  typedef logic [`CACHE_WORD_IDX_W-1:0] word_idx_t;

  // ==========================================================
  // Requester payload
  // ==========================================================

  // One requester data word
  typedef logic [31:0] word_t;

  // Byte enables, bit n covers bits 8n+7..8n
  typedef logic [3:0] byte_strb_t;

endpackage

/* source/cache_bus_pkg.sv */
`include "cache_defs.svh"

package cache_bus_pkg;

  // Byte address on the memory bus
  typedef logic [`CACHE_ADDR_W-1:0] bus_addr_t;

  // One data beat
  typedef logic [`BUS_DATA_W-1:0] bus_data_t;

  // Byte strobes of a beat
  typedef logic [`BUS_DATA_W/8-1:0] bus_strb_t;

  // Which 32-bit lane of a beat holds a word
  // Taken from address bit 2
  typedef logic [`BUS_LANE_W-1:0] lane_idx_t;

endpackage

/* source/cache_ctrl_fsm.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module cache_ctrl_fsm
  import cache_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_rd_valid,
  input  bus_addr_t i_rd_addr,
  input  logic      i_wr_valid,
  input  logic      i_rd_hit,
  input  logic      i_fill_done,
  input  logic      i_wr_done,
  input  logic      i_ar_ready,
  output logic      o_rd_ready,
  output logic      o_rd_accept,
  output logic      o_wr_accept,
  output logic      o_filling,
  output logic      o_fill_start,
  output logic      o_wr_start,
  output logic      o_ar_valid,
  output bus_addr_t o_ar_addr
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FILL,
    ST_WRITE
  } state_t;

  // Clears the offset bits of a byte address
  localparam bus_addr_t LINE_MASK = ~bus_addr_t'(`CACHE_LINE_BYTES - 1);

  state_t state;
  logic   idle;

  // ==========================================================
  // Request decode
  // ==========================================================
  assign idle = (state == ST_IDLE);

  // Ready only for a hit, a miss keeps the requester waiting
  assign o_rd_ready  = idle && i_rd_hit;
  assign o_rd_accept = o_rd_ready && i_rd_valid;

  // Miss starts a line fill
  assign o_fill_start = idle && i_rd_valid && !i_rd_hit;

  // Reads win over writes
  assign o_wr_accept = idle && i_wr_valid && !i_rd_valid;
  // Write-through always follows an accepted write, hit or miss
  assign o_wr_start  = o_wr_accept;

  assign o_filling = (state == ST_FILL);

  // ==========================================================
  // State and read-address valid
  // ==========================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ST_IDLE;
      o_ar_valid <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (o_fill_start) begin
            state      <= ST_FILL;
            o_ar_valid <= 1'b1;
          end else if (o_wr_start) begin
            state <= ST_WRITE;
          end
        end
        ST_FILL: begin
          // Address valid held until the slave takes it
          if (o_ar_valid && i_ar_ready) begin
            o_ar_valid <= 1'b0;
          end
          // Back to idle, the held read then hits
          if (i_fill_done) begin
            state <= ST_IDLE;
          end
        end
        ST_WRITE: begin
          if (i_wr_done) begin
            state <= ST_IDLE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Line-aligned burst address, captured at miss
  always_ff @(posedge clk) begin
    if (o_fill_start) begin
      o_ar_addr <= i_rd_addr & LINE_MASK;
    end
  end

endmodule

/* source/fill_beat_counter.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module fill_beat_counter
  import cache_geom_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_start,
  input  logic      i_filling,
  input  logic      i_r_valid,
  input  logic      i_r_last,
  output word_idx_t o_word_idx,
  output logic      o_fill_done
);

  logic beat;

  // Beat only counts inside a fill
  assign beat = i_filling && i_r_valid;

  // First word of the next beat
  // Beat k lands on words 2k and 2k+1
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_word_idx <= '0;
    end else if (i_start) begin
      o_word_idx <= '0;
    end else if (beat) begin
      o_word_idx <= o_word_idx + word_idx_t'(`BUS_WORDS_PER_BEAT);
    end
  end

  // Last beat of the burst closes the line
  assign o_fill_done = beat && i_r_last;

endmodule

/* source/tag_store.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module tag_store
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  bus_addr_t i_rd_addr,
  input  bus_addr_t i_wr_addr,
  input  logic      i_fill_done,
  output logic      o_rd_hit,
  output logic      o_wr_hit
);

  logic valid_bits [`CACHE_SETS];
  tag_t tags       [`CACHE_SETS];

  tag_t rd_tag;
  set_t rd_set;
  tag_t wr_tag;
  set_t wr_set;

  // ==========================================================
  // Address split
  // ==========================================================
  assign rd_tag = i_rd_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign rd_set = i_rd_addr[`CACHE_OFFSET_W +: `CACHE_SET_W];
  assign wr_tag = i_wr_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
  assign wr_set = i_wr_addr[`CACHE_OFFSET_W +: `CACHE_SET_W];

  // Both lookups are combinational
  assign o_rd_hit = valid_bits[rd_set] && (tags[rd_set] == rd_tag);
  assign o_wr_hit = valid_bits[wr_set] && (tags[wr_set] == wr_tag);

  // ==========================================================
  // Update at end of fill
  // ==========================================================

  // Fill always targets the set of the held read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        valid_bits[s] <= 1'b0;
      end
    end else if (i_fill_done) begin
      valid_bits[rd_set] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fill_done) begin
      tags[rd_set] <= rd_tag;
    end
  end

endmodule

/* source/line_store.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module line_store
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  bus_addr_t  i_rd_addr,
  input  logic       i_rd_accept,
  input  bus_addr_t  i_wr_addr,
  input  word_t      i_wr_data,
  input  byte_strb_t i_wr_strb,
  input  logic       i_wr_en,
  input  logic       i_fill_en,
  input  word_idx_t  i_fill_word_idx,
  input  bus_data_t  i_fill_data,
  output word_t      o_rd_data,
  output logic       o_rd_data_valid
);

  word_t data_mem [`CACHE_SETS][`CACHE_WORDS_PER_LINE];

  set_t      rd_set;
  word_idx_t rd_word;
  set_t      wr_set;
  word_idx_t wr_word;

  assign rd_set  = i_rd_addr[`CACHE_OFFSET_W +: `CACHE_SET_W];
  assign rd_word = i_rd_addr[2 +: `CACHE_WORD_IDX_W];
  assign wr_set  = i_wr_addr[`CACHE_OFFSET_W +: `CACHE_SET_W];
  assign wr_word = i_wr_addr[2 +: `CACHE_WORD_IDX_W];

  // ==========================================================
  // Array writes
  // ==========================================================

  // Fills and write hits never share a cycle
  always_ff @(posedge clk) begin
    if (i_fill_en) begin
      // Whole beat into the held read's set
      for (int i = 0; i < `BUS_WORDS_PER_BEAT; i++) begin
        data_mem[rd_set][i_fill_word_idx + word_idx_t'(i)] <= i_fill_data[32*i +: 32];
      end
    end else if (i_wr_en) begin
      // Byte merge under strobes
      for (int b = 0; b < 4; b++) begin
        if (i_wr_strb[b]) begin
          data_mem[wr_set][wr_word][8*b +: 8] <= i_wr_data[8*b +: 8];
        end
      end
    end
  end

  // ==========================================================
  // Read port
  // ==========================================================

  // Word and valid pulse land together, one cycle after accept
  always_ff @(posedge clk) begin
    if (i_rd_accept) begin
      o_rd_data <= data_mem[rd_set][rd_word];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_rd_data_valid <= 1'b0;
    end else begin
      o_rd_data_valid <= i_rd_accept;
    end
  end

endmodule

/* source/write_through_port.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module write_through_port
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       i_wr_start,
  input  bus_addr_t  i_wr_addr,
  input  word_t      i_wr_data,
  input  byte_strb_t i_wr_strb,
  input  logic       i_aw_ready,
  input  logic       i_w_ready,
  output logic       o_aw_valid,
  output bus_addr_t  o_aw_addr,
  output logic       o_w_valid,
  output bus_data_t  o_w_data,
  output bus_strb_t  o_w_strb,
  output logic       o_wr_done
);

  lane_idx_t lane;
  logic      wr_active;
  logic      aw_done;
  logic      w_done;
  logic      aw_fire;
  logic      w_fire;

  // ==========================================================
  // Channel payload
  // ==========================================================

  // Requester holds the write until done, so payload comes straight through
  assign o_aw_addr = i_wr_addr;
  assign lane      = i_wr_addr[2 +: `BUS_LANE_W];

  // Word in its own lane, other lane zero
  always_comb begin
    o_w_data              = '0;
    o_w_strb              = '0;
    o_w_data[32*lane +: 32] = i_wr_data;
    o_w_strb[4*lane +: 4]   = i_wr_strb;
  end

  // ==========================================================
  // Handshakes and completion
  // ==========================================================
  assign aw_fire = o_aw_valid && i_aw_ready;
  assign w_fire  = o_w_valid && i_w_ready;

  // Done in the cycle the later of the two handshakes lands
  assign o_wr_done = wr_active && (aw_done || aw_fire) && (w_done || w_fire);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_aw_valid <= 1'b0;
      o_w_valid  <= 1'b0;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
      wr_active  <= 1'b0;
    end else if (i_wr_start) begin
      o_aw_valid <= 1'b1;
      o_w_valid  <= 1'b1;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
      wr_active  <= 1'b1;
    end else begin
      // Each channel drops on its own handshake
      if (aw_fire) begin
        o_aw_valid <= 1'b0;
        aw_done    <= 1'b1;
      end
      if (w_fire) begin
        o_w_valid <= 1'b0;
        w_done    <= 1'b1;
      end
      // One-cycle done pulse
      if (o_wr_done) begin
        wr_active <= 1'b0;
      end
    end
  end

endmodule

/* source/wt_cache_top.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module wt_cache_top
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,

  // Requester reads
  input  logic       i_rd_valid,
  input  bus_addr_t  i_rd_addr,
  output logic       o_rd_ready,
  output word_t      o_rd_data,
  output logic       o_rd_data_valid,

  // Requester writes
  input  logic       i_wr_valid,
  input  bus_addr_t  i_wr_addr,
  input  word_t      i_wr_data,
  input  byte_strb_t i_wr_strb,
  output logic       o_wr_ready,

  // Bus read address and data
  output logic       o_ar_valid,
  output bus_addr_t  o_ar_addr,
  input  logic       i_ar_ready,
  input  logic       i_r_valid,
  input  bus_data_t  i_r_data,
  input  logic       i_r_last,

  // Bus write address and data
  output logic       o_aw_valid,
  output bus_addr_t  o_aw_addr,
  input  logic       i_aw_ready,
  output logic       o_w_valid,
  output bus_data_t  o_w_data,
  output bus_strb_t  o_w_strb,
  input  logic       i_w_ready
);

  logic      rd_hit;
  logic      wr_hit;
  logic      rd_accept;
  logic      wr_accept;
  logic      wr_start;
  logic      filling;
  logic      fill_start;
  logic      fill_done;
  logic      wr_hit_en;
  word_idx_t fill_word_idx;

  // ==========================================================
  // Control
  // ==========================================================
  cache_ctrl_fsm u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_rd_valid   (i_rd_valid),
    .i_rd_addr    (i_rd_addr),
    .i_wr_valid   (i_wr_valid),
    .i_rd_hit     (rd_hit),
    .i_fill_done  (fill_done),
    .i_wr_done    (o_wr_ready),
    .i_ar_ready   (i_ar_ready),
    .o_rd_ready   (o_rd_ready),
    .o_rd_accept  (rd_accept),
    .o_wr_accept  (wr_accept),
    .o_filling    (filling),
    .o_fill_start (fill_start),
    .o_wr_start   (wr_start),
    .o_ar_valid   (o_ar_valid),
    .o_ar_addr    (o_ar_addr)
  );

  fill_beat_counter u_fill_cnt (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_start     (fill_start),
    .i_filling   (filling),
    .i_r_valid   (i_r_valid),
    .i_r_last    (i_r_last),
    .o_word_idx  (fill_word_idx),
    .o_fill_done (fill_done)
  );

  // ==========================================================
  // Storage
  // ==========================================================
  tag_store u_tags (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_rd_addr   (i_rd_addr),
    .i_wr_addr   (i_wr_addr),
    .i_fill_done (fill_done),
    .o_rd_hit    (rd_hit),
    .o_wr_hit    (wr_hit)
  );

  // Cached copy only updated on a write hit
  assign wr_hit_en = wr_accept & wr_hit;

  // Read beats only ever answer our own fill burst
  line_store u_lines (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_rd_addr       (i_rd_addr),
    .i_rd_accept     (rd_accept),
    .i_wr_addr       (i_wr_addr),
    .i_wr_data       (i_wr_data),
    .i_wr_strb       (i_wr_strb),
    .i_wr_en         (wr_hit_en),
    .i_fill_en       (i_r_valid),
    .i_fill_word_idx (fill_word_idx),
    .i_fill_data     (i_r_data),
    .o_rd_data       (o_rd_data),
    .o_rd_data_valid (o_rd_data_valid)
  );

  // ==========================================================
  // Write-through to memory
  // ==========================================================
  write_through_port u_wt_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_wr_start (wr_start),
    .i_wr_addr  (i_wr_addr),
    .i_wr_data  (i_wr_data),
    .i_wr_strb  (i_wr_strb),
    .i_aw_ready (i_aw_ready),
    .i_w_ready  (i_w_ready),
    .o_aw_valid (o_aw_valid),
    .o_aw_addr  (o_aw_addr),
    .o_w_valid  (o_w_valid),
    .o_w_data   (o_w_data),
    .o_w_strb   (o_w_strb),
    .o_wr_done  (o_wr_ready)
  );

endmodule

/* sim/mem_responder.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module mem_responder
  import cache_bus_pkg::*;
#(
  parameter int SEED = 72680
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      i_ar_valid,
  input  bus_addr_t i_ar_addr,
  output logic      o_ar_ready,
  output logic      o_r_valid,
  output bus_data_t o_r_data,
  output logic      o_r_last,
  input  logic      i_aw_valid,
  input  bus_addr_t i_aw_addr,
  output logic      o_aw_ready,
  input  logic      i_w_valid,
  input  bus_data_t i_w_data,
  input  bus_strb_t i_w_strb,
  output logic      o_w_ready,
  output int        o_ar_count
);

  // 1 KB as 256 words
  logic [31:0] mem [256];

  integer    seed;
  logic      pend;
  bus_addr_t pend_addr;
  logic      beat_idx;
  logic [7:0] widx;

  initial begin
    seed = SEED;
    for (int i = 0; i < 256; i++) begin
      mem[i] = $random(seed);
    end
    o_ar_ready = 1'b0;
    o_r_valid  = 1'b0;
    o_r_data   = '0;
    o_r_last   = 1'b0;
    o_aw_ready = 1'b0;
    o_w_ready  = 1'b0;
    o_ar_count = 0;
    pend       = 1'b0;
    pend_addr  = '0;
    beat_idx   = 1'b0;
  end

  // ==========================================================
  // Handshakes seen at the rising edge
  // ==========================================================
  always @(posedge clk) begin
    if (rst_n) begin
      if (i_ar_valid && o_ar_ready) begin
        pend_addr  <= i_ar_addr;
        pend       <= 1'b1;
        beat_idx   <= 1'b0;
        o_ar_count <= o_ar_count + 1;
      end
      if (o_r_valid) begin
        beat_idx <= 1'b1;
        if (o_r_last) begin
          pend <= 1'b0;
        end
      end
      // Address is still held by the requester when the data lands
      if (i_w_valid && o_w_ready) begin
        widx = {i_aw_addr[9:3], 1'b0};
        for (int b = 0; b < 8; b++) begin
          if (i_w_strb[b]) begin
            mem[widx + 8'(b / 4)][8*(b%4) +: 8] <= i_w_data[8*b +: 8];
          end
        end
      end
    end
  end

  // ==========================================================
  // Random ready and valid, driven on the falling edge
  // ==========================================================
  always @(negedge clk) begin
    if (!rst_n) begin
      o_ar_ready <= 1'b0;
      o_aw_ready <= 1'b0;
      o_w_ready  <= 1'b0;
      o_r_valid  <= 1'b0;
    end else begin
      // Ready about three cycles out of four
      o_ar_ready <= (($random(seed) & 3) != 0);
      o_aw_ready <= (($random(seed) & 3) != 0);
      o_w_ready  <= (($random(seed) & 3) != 0);
      if (pend && (($random(seed) & 1) != 0)) begin
        o_r_valid <= 1'b1;
        o_r_data  <= {mem[{pend_addr[9:4], beat_idx, 1'b1}],
                      mem[{pend_addr[9:4], beat_idx, 1'b0}]};
        o_r_last  <= beat_idx;
      end else begin
        o_r_valid <= 1'b0;
        o_r_last  <= 1'b0;
      end
    end
  end

endmodule

/* sim/tb_wt_cache_top.sv */
`timescale 1ns/10ps

`include "cache_defs.svh"

module tb_wt_cache_top
  import cache_geom_pkg::*;
  import cache_bus_pkg::*;
;

  localparam int N_RANDOM   = 300;
  localparam int N_DIRECTED = 16;
  localparam int LIMIT      = 40 * (N_RANDOM + N_DIRECTED);
  localparam int MEM_WORDS  = 256;

  logic clk;
  logic rst_n;
  logic i_rd_valid, o_rd_ready, o_rd_data_valid;
  bus_addr_t i_rd_addr;
  word_t o_rd_data;
  logic i_wr_valid, o_wr_ready;
  bus_addr_t i_wr_addr;
  word_t i_wr_data;
  byte_strb_t i_wr_strb;
  logic o_ar_valid, i_ar_ready, i_r_valid, i_r_last;
  bus_addr_t o_ar_addr;
  bus_data_t i_r_data;
  logic o_aw_valid, i_aw_ready, o_w_valid, i_w_ready;
  bus_addr_t o_aw_addr;
  bus_data_t o_w_data;
  bus_strb_t o_w_strb;
  int ar_count;

  integer seed;
  int cycles;
  int errors;
  word_t shadow [MEM_WORDS];
  word_t exp_q [$];
  bus_addr_t lines [8];

  wt_cache_top i_wt_cache_top (.*);

  mem_responder #(.SEED(72680)) i_mem (
    .clk(clk), .rst_n(rst_n),
    .i_ar_valid(o_ar_valid), .i_ar_addr(o_ar_addr), .o_ar_ready(i_ar_ready),
    .o_r_valid(i_r_valid), .o_r_data(i_r_data), .o_r_last(i_r_last),
    .i_aw_valid(o_aw_valid), .i_aw_addr(o_aw_addr), .o_aw_ready(i_aw_ready),
    .i_w_valid(o_w_valid), .i_w_data(o_w_data), .i_w_strb(o_w_strb),
    .o_w_ready(i_w_ready), .o_ar_count(ar_count)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==========================================================
  // Reference model and checks
  // ==========================================================

  // Expected word straight from the shadow memory
  function automatic word_t ref_word(bus_addr_t addr);
    return shadow[addr[9:2]];
  endfunction

  task automatic check(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  // Read data compared in issue order
  always @(negedge clk) begin
    if (rst_n && o_rd_data_valid) begin
      if (exp_q.size() == 0) begin
        $display("Read data returned with no read outstanding");
        $display("Test failed");
        $fatal(1);
      end else begin
        check("o_rd_data", o_rd_data, exp_q.pop_front());
      end
    end
  end

  // Hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout after %0d cycles, the cache stopped answering", cycles);
      $display("Test failed");
      $fatal(1);
    end
  end

  // ==========================================================
  // Requester tasks
  // ==========================================================
  task automatic read_word(bus_addr_t addr, int exp_ar);
    int ar0;
    ar0 = ar_count;
    @(negedge clk);
    i_rd_valid = 1'b1;
    i_rd_addr  = addr;
    #1;
    while (!o_rd_ready) begin
      // Burst address is the line base
      if (o_ar_valid) begin
        check("o_ar_addr", o_ar_addr, {addr[31:4], 4'h0});
      end
      @(negedge clk);
      #1;
    end
    exp_q.push_back(ref_word(addr));
    @(negedge clk);
    i_rd_valid = 1'b0;
    // Word lands one cycle after the accepting edge
    check("o_rd_data_valid", o_rd_data_valid, 1'b1);
    if (exp_ar >= 0) begin
      check("ar_handshakes", ar_count - ar0, exp_ar);
    end
  endtask

  task automatic write_word(bus_addr_t addr, word_t data, byte_strb_t strb);
    logic [63:0] exp_data;
    logic [7:0]  exp_strb;
    logic        done;
    // Lane picked by address bit 2 with the other lane zero
    exp_data = addr[2] ? {data, 32'h0} : {32'h0, data};
    exp_strb = addr[2] ? {strb, 4'h0} : {4'h0, strb};
    @(negedge clk);
    i_wr_valid = 1'b1;
    i_wr_addr  = addr;
    i_wr_data  = data;
    i_wr_strb  = strb;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        shadow[addr[9:2]][8*b +: 8] = data[8*b +: 8];
      end
    end
    #1;
    done = 1'b0;
    // Payload checked in every cycle a channel is valid, the last one too
    while (!done) begin
      if (o_aw_valid) begin
        check("o_aw_addr", o_aw_addr, addr);
      end
      if (o_w_valid) begin
        check("o_w_data", o_w_data, exp_data);
        check("o_w_strb", o_w_strb, exp_strb);
      end
      done = o_wr_ready;
      if (!done) begin
        @(negedge clk);
        #1;
      end
    end
    @(negedge clk);
    i_wr_valid = 1'b0;
    // Done is a single pulse
    check("o_wr_ready", o_wr_ready, 1'b0);
    check("mem_word", i_mem.mem[addr[9:2]], shadow[addr[9:2]]);
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    bus_addr_t a;
    seed       = 72680;
    cycles     = 0;
    errors     = 0;
    rst_n      = 1'b0;
    i_rd_valid = 1'b0;
    i_rd_addr  = '0;
    i_wr_valid = 1'b0;
    i_wr_addr  = '0;
    i_wr_data  = '0;
    i_wr_strb  = '0;
    lines = '{32'h000, 32'h010, 32'h020, 32'h030, 32'h100, 32'h110, 32'h200, 32'h310};
    repeat (3) @(negedge clk);
    for (int i = 0; i < MEM_WORDS; i++) begin
      shadow[i] = i_mem.mem[i];
    end
    // Outputs quiet in reset
    check("o_ar_valid", o_ar_valid, 1'b0);
    check("o_aw_valid", o_aw_valid, 1'b0);
    check("o_w_valid", o_w_valid, 1'b0);
    check("o_rd_data_valid", o_rd_data_valid, 1'b0);
    check("o_rd_ready", o_rd_ready, 1'b0);
    check("o_wr_ready", o_wr_ready, 1'b0);
    rst_n = 1'b1;
    @(negedge clk);
    check("o_ar_valid", o_ar_valid, 1'b0);
    check("o_aw_valid", o_aw_valid, 1'b0);
    check("o_w_valid", o_w_valid, 1'b0);
    check("o_rd_data_valid", o_rd_data_valid, 1'b0);
    check("o_rd_ready", o_rd_ready, 1'b0);
    check("o_wr_ready", o_wr_ready, 1'b0);

    // First read misses and the same line then hits
    read_word(32'h040, 1);
    read_word(32'h044, 0);
    // Write hit with mixed strobes
    write_word(32'h044, 32'hA5A5_5A5A, 4'b0101);
    read_word(32'h044, 0);
    // Write miss updates memory only
    write_word(32'h0C8, 32'h1234_5678, 4'b0011);
    read_word(32'h0C8, 1);
    // Same set with different tags
    for (int k = 0; k < 2; k++) begin
      read_word(32'h100, 1);
      read_word(32'h304, 1);
    end

    // Random mix over eight lines
    for (int n = 0; n < N_RANDOM; n++) begin
      a = lines[$unsigned($random(seed)) % 8] | bus_addr_t'(($random(seed) & 3) << 2);
      if ($random(seed) & 1) begin
        read_word(a, -1);
      end else begin
        write_word(a, $random(seed), 4'($random(seed)));
      end
    end

    repeat (2) @(negedge clk);
    if (exp_q.size() != 0) begin
      $display("Some reads never returned data");
      errors++;
    end
    if (errors == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule

/* wt_cache_top.f */
+incdir+include
source/cache_geom_pkg.sv
source/cache_bus_pkg.sv
source/cache_ctrl_fsm.sv
source/fill_beat_counter.sv
source/tag_store.sv
source/line_store.sv
source/write_through_port.sv
source/wt_cache_top.sv
sim/mem_responder.sv
sim/tb_wt_cache_top.sv

/* Makefile */
# Verilator flow for the write-through cache
VERILATOR ?= verilator
TOP       ?= tb_wt_cache_top
FILELIST  ?= wt_cache_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -j 0

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	elif grep -q "Test completed successfully" $(LOG); then \
	  echo "Simulation PASSED"; \
	else \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
